// File: verilog.f
source/ps2_mouse_pkg.sv
source/ps2_rx_shifter.sv
source/ps2_tx_shifter.sv
source/ps2_mouse_ctrl.sv
source/mouse_position.sv
source/mouse_apb_regs.sv
source/ps2_mouse_top.sv
tests/tb_clock.sv
tests/ps2_mouse_assert.sv
tests/ps2_mouse_tb.sv

// File: Makefile
# Verilator build, run and lint for the PS/2 mouse subsystem

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = ps2_mouse_tb
LINT_TOP  = ps2_mouse_top
FILELIST  = verilog.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_TEXT = Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# the log search decides the result
run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: tests/ps2_mouse_tb.sv
/* testbench for the PS/2 mouse subsystem
   PS/2 device model, APB read and write tasks, position reference model, six tests */
`timescale 1ns/100ps
`default_nettype none

module ps2_mouse_tb;

	localparam int HALF_CLK = 20;                  // device clock half period, cycles
	localparam int NUM_FRAMES = 130;               // two handshakes, 41 packets, spare
	localparam int CYCLE_LIMIT = 6 * int'(ps2_mouse_pkg::TIMEOUT_CYCLES) + 200 * NUM_FRAMES;

	logic clk;
	logic mrreset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [4:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic ps2_clk_o;
	logic ps2_data_o;
	logic dev_clk;                                 // device side of the lines
	logic dev_data;
	logic ps2_clk_line;
	logic ps2_data_line;

	logic [15:0] x_model;                          // reference model state
	logic [15:0] y_model;
	logic [2:0] btn_model;
	logic [15:0] pkt_model;
	logic [7:0] err_model;
	int errors;
	int test_start_errors;
	int tests_run;
	int tests_failed;
	int cycles = 0;

	assign ps2_clk_line = dev_clk & ps2_clk_o;     // open collector wired and
	assign ps2_data_line = dev_data & ps2_data_o;

	tb_clock u_clock (.clk(clk));

	ps2_mouse_top UUT (.clk(clk), .mrreset(mrreset), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.ps2_clk_i(ps2_clk_line), .ps2_data_i(ps2_data_line), .ps2_clk_o(ps2_clk_o),
		.ps2_data_o(ps2_data_o));

	bind ps2_mouse_ctrl ps2_mouse_assert u_assert (.clk(clk), .mrreset(mrreset),
		.enable(enable), .tx_start(tx_start), .pkt_strobe(pkt_strobe),
		.ps2_clk_o(ps2_clk_o));

	// run limit
	always @(negedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// --------------------------------------------------
	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
		errors++;
		$display("error: %s expected %h got %h", name, exp, got);
	endtask

	task automatic failure(input string what);
		errors++;
		$display("%s", what);
	endtask

	task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
		@(negedge clk);
		psel = 1'b1;                               // setup phase
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;                            // access, write lands at next rise
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [4:0] addr, output logic [31:0] data);
		@(negedge clk);
		psel = 1'b1;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clk);
		penable = 1'b1;
		@(posedge clk);
		data = prdata;                             // captured as the access phase ends
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic read_check(input logic [4:0] addr, input string name,
		input logic [31:0] exp);
		logic [31:0] got;
		apb_read(addr, got);
		if (got !== exp)
			mismatch(name, got, exp);
	endtask

	// --------------------------------------------------
	task automatic send_byte(input logic [7:0] b, input logic bad_parity);
		logic [10:0] frame;
		frame = {1'b1, ~^b ^ bad_parity, b, 1'b0};  // stop, parity, data, start
		for (int i = 0; i < 11; i++)
		begin
			dev_data = frame[0];
			frame = {1'b1, frame[10:1]};
			wait_cycles(HALF_CLK / 2);
			dev_clk = 1'b0;                        // host samples on the fall
			wait_cycles(HALF_CLK);
			dev_clk = 1'b1;
			wait_cycles(HALF_CLK / 2);
		end
		dev_data = 1'b1;
		wait_cycles(2 * HALF_CLK);                 // idle gap
	endtask

	// inhibit, request to send, then clock in the host command
	task automatic expect_command(input int wait_limit);
		int waited;
		int low_cycles;
		logic [9:0] bits;
		waited = 0;
		low_cycles = 0;
		bits = '0;
		while (ps2_clk_line && waited < wait_limit)
		begin
			wait_cycles(1);
			waited++;
		end
		if (ps2_clk_line)
			failure("host never inhibited the clock");
		else
		begin
			while (!ps2_clk_line)
			begin
				wait_cycles(1);
				low_cycles++;
			end
			if (low_cycles < int'(ps2_mouse_pkg::HOLD_CYCLES))
				failure($sformatf("clock inhibit lasted only %0d cycles", low_cycles));
			if (ps2_data_line !== 1'b0)
				failure("no request to send after the clock was released");
			wait_cycles(HALF_CLK / 2);
			for (int i = 0; i < 11; i++)
			begin
				dev_clk = 1'b0;
				wait_cycles(HALF_CLK);
				if (i < 10)
					bits = {ps2_data_line, bits[9:1]};   // read before the rise
				dev_clk = 1'b1;
				wait_cycles(HALF_CLK);
			end
			if (bits[7:0] !== ps2_mouse_pkg::CMD_ENABLE)
				mismatch("command byte", {24'd0, bits[7:0]}, {24'd0, ps2_mouse_pkg::CMD_ENABLE});
			if (^bits[8:0] !== 1'b1)
				failure("command parity is not odd");
			if (bits[9] !== 1'b1)
				failure("command stop bit missing");
		end
	endtask

	task automatic random_packet();
		logic [7:0] status_byte;
		logic [7:0] x_raw;
		logic [7:0] y_raw;
		int dx;
		int dy;
		status_byte = 8'($urandom);
		status_byte[3] = 1'b1;                     // sync bit
		status_byte[7:6] = ($urandom % 6 == 0) ? 2'($urandom % 3 + 1) : 2'b00;
		x_raw = 8'($urandom);
		y_raw = 8'($urandom);
		dx = status_byte[4] ? int'(x_raw) - 256 : int'(x_raw);   // 9-bit signed
		dy = status_byte[5] ? int'(y_raw) - 256 : int'(y_raw);
		send_byte(status_byte, 1'b0);
		send_byte(x_raw, 1'b0);
		send_byte(y_raw, 1'b0);
		if (status_byte[7:6] == 2'b00)
		begin
			x_model = x_model + 16'(dx);
			y_model = y_model - 16'(dy);           // screen direction
		end
		btn_model = status_byte[2:0];
		pkt_model = pkt_model + 16'd1;
	endtask

	task automatic wait_packets(input logic [15:0] count);
		logic [31:0] got;
		int polls;
		polls = 0;
		do
		begin
			apb_read(ps2_mouse_pkg::REG_COUNT, got);
			polls++;
		end
		while (got[15:0] !== count && polls < 100);
		if (got[15:0] !== count)
			failure($sformatf("packet count never reached %0d", count));
	endtask

	task automatic wait_ready();
		logic [31:0] got;
		int polls;
		polls = 0;
		do
		begin
			apb_read(ps2_mouse_pkg::REG_STATUS, got);
			polls++;
		end
		while (got[3] !== 1'b1 && polls < 100);
		if (got[3] !== 1'b1)
			failure("ready did not rise after the acknowledge");
	endtask

	task automatic check_model();
		read_check(ps2_mouse_pkg::REG_XPOS, "x_pos", {{16{x_model[15]}}, x_model});
		read_check(ps2_mouse_pkg::REG_YPOS, "y_pos", {{16{y_model[15]}}, y_model});
		read_check(ps2_mouse_pkg::REG_STATUS, "status", {28'd0, 1'b1, btn_model});
		read_check(ps2_mouse_pkg::REG_COUNT, "count", {8'd0, err_model, pkt_model});
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_start_errors)
			$display("test %0d %s: ok", tests_run, name);
		else
		begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - test_start_errors);
		end
		test_start_errors = errors;
	endtask

	// --------------------------------------------------
	initial
	begin
		void'($urandom(35597));                    // single seed for the run
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 5'd0;
		pwdata = 32'd0;
		dev_clk = 1'b1;                            // device lines released
		dev_data = 1'b1;
		mrreset = 1'b1;
		x_model = 16'd0;
		y_model = 16'd0;
		btn_model = 3'd0;
		pkt_model = 16'd0;
		err_model = 8'd0;
		errors = 0;
		test_start_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		wait_cycles(5);
		mrreset = 1'b0;

		// reset state
		read_check(ps2_mouse_pkg::REG_CTRL, "ctrl", 32'd0);
		read_check(ps2_mouse_pkg::REG_STATUS, "status", 32'd0);
		read_check(ps2_mouse_pkg::REG_XPOS, "x_pos", 32'd0);
		read_check(ps2_mouse_pkg::REG_YPOS, "y_pos", 32'd0);
		read_check(ps2_mouse_pkg::REG_COUNT, "count", 32'd0);
		if (ps2_clk_o !== 1'b1)
			mismatch("ps2_clk_o", {31'd0, ps2_clk_o}, 32'd1);
		if (ps2_data_o !== 1'b1)
			mismatch("ps2_data_o", {31'd0, ps2_data_o}, 32'd1);
		end_test("reset values");

		apb_write(ps2_mouse_pkg::REG_CTRL, 32'h1);
		expect_command(100);
		read_check(ps2_mouse_pkg::REG_STATUS, "status", 32'd0);   // no ready before ack
		wait_cycles(2 * HALF_CLK);
		send_byte(ps2_mouse_pkg::ACK_BYTE, 1'b0);
		wait_ready();
		end_test("enable handshake");

		for (int n = 0; n < 40; n++)
		begin
			random_packet();
			wait_packets(pkt_model);
			check_model();
		end
		end_test("random packets");

		send_byte(8'h08 | 8'($urandom % 8), 1'b1);   // status byte, parity flipped
		err_model = err_model + 8'd1;
		random_packet();
		wait_packets(pkt_model);
		check_model();
		end_test("parity error");

		send_byte(8'h08, 1'b0);                    // byte 1, then the device stalls
		expect_command(int'(ps2_mouse_pkg::TIMEOUT_CYCLES) + 500);
		read_check(ps2_mouse_pkg::REG_STATUS, "status", {28'd0, 1'b0, btn_model});
		wait_cycles(2 * HALF_CLK);
		send_byte(ps2_mouse_pkg::ACK_BYTE, 1'b0);
		wait_ready();
		end_test("watchdog restart");

		apb_write(ps2_mouse_pkg::REG_CTRL, 32'h3);  // stay enabled, pulse clear
		x_model = 16'd0;
		y_model = 16'd0;
		check_model();
		apb_write(ps2_mouse_pkg::REG_STATUS, 32'hFFFF_FFFF);   // read-only register
		check_model();
		read_check(ps2_mouse_pkg::REG_CTRL, "ctrl", 32'd1);
		read_check(5'd20, "unmapped 0x14", 32'd0);
		read_check(5'd2, "unmapped 0x02", 32'd0);
		end_test("clear and register map");

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/ps2_mouse_assert.sv
/* concurrent assertions on the PS/2 mouse controller
   strobe width, command launch point, clock release while disabled */
`timescale 1ns/100ps
`default_nettype none

module ps2_mouse_assert
(
	input wire clk,
	input wire mrreset,
	input wire enable,
	input wire tx_start,
	input wire pkt_strobe,
	input wire ps2_clk_o
);

	int low_run;                       // cycles the clock has been held low

	always_ff @(posedge clk)
	begin
		if (mrreset || ps2_clk_o)
			low_run <= 0;
		else
			low_run <= low_run + 1;
	end

	// --------------------------------------------------
	strobe_one_cycle: assert property (@(posedge clk) disable iff (mrreset)
		pkt_strobe |=> !pkt_strobe)
		else $error("pkt_strobe high for more than one cycle");

	// command only leaves after a full inhibit
	start_after_hold: assert property (@(posedge clk) disable iff (mrreset)
		tx_start |-> (!ps2_clk_o && low_run >= int'(ps2_mouse_pkg::HOLD_CYCLES) - 1))
		else $error("tx_start before the clock was inhibited long enough");

	// still released in the cycle after, even as enable comes back
	clock_released_idle: assert property (@(posedge clk) disable iff (mrreset)
		!enable |=> ps2_clk_o)
		else $error("ps2_clk_o driven low while disabled");

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
/* testbench clock source
   free running clock with an 8 ns period */
`timescale 1ns/100ps
`default_nettype none

module tb_clock
(
	output logic clk
);

	localparam int HALF_PERIOD = 4;        // ns

	initial
	begin
		clk = 1'b0;                        // first rise at 4 ns
		forever
			#(HALF_PERIOD) clk = ~clk;
	end

endmodule

`default_nettype wire

// File: source/ps2_mouse_top.sv
/* PS/2 mouse subsystem top
   APB registers, controller, receive and transmit shifters, position block */
`timescale 1ns/100ps
`default_nettype none

module ps2_mouse_top
(
	input  wire         clk,
	input  wire         mrreset,
	input  wire         psel,
	input  wire         penable,
	input  wire         pwrite,
	input  wire  [4:0]  paddr,
	input  wire  [31:0] pwdata,
	output logic [31:0] prdata,
	input  wire         ps2_clk_i,
	input  wire         ps2_data_i,
	output logic        ps2_clk_o,     // open collector, 1 releases
	output logic        ps2_data_o
);

	logic enable;
	logic clear;
	logic reinit;
	logic ready;
	logic clk_fall;
	logic rx_valid;
	logic rx_error;
	logic [7:0] rx_data;
	logic rx_hold;
	logic tx_start;
	logic tx_done;
	logic pkt_strobe;
	logic frame_err;
	logic [1:0] pkt_index;
	ps2_mouse_pkg::packet_byte_t pkt_byte;
	logic [2:0] buttons;
	logic [ps2_mouse_pkg::POS_BITS-1:0] x_pos;
	logic [ps2_mouse_pkg::POS_BITS-1:0] y_pos;
	logic [15:0] pkt_count;
	logic [7:0] err_count;

	// --------------------------------------------------
	mouse_apb_regs u_regs (.clk(clk), .mrreset(mrreset), .psel(psel), .penable(penable),
		.pwrite(pwrite), .ready(ready), .paddr(paddr), .pwdata(pwdata), .buttons(buttons),
		.x_pos(x_pos), .y_pos(y_pos), .pkt_count(pkt_count), .err_count(err_count),
		.prdata(prdata), .enable(enable), .clear(clear), .reinit(reinit));

	ps2_rx_shifter u_rx (.clk(clk), .mrreset(mrreset), .ps2_clk_i(ps2_clk_i),
		.ps2_data_i(ps2_data_i), .rx_hold(rx_hold), .clk_fall(clk_fall),
		.rx_valid(rx_valid), .rx_error(rx_error), .rx_data(rx_data));

	ps2_tx_shifter u_tx (.clk(clk), .mrreset(mrreset), .clk_fall(clk_fall),
		.tx_start(tx_start), .ps2_data_o(ps2_data_o), .tx_done(tx_done));

	ps2_mouse_ctrl u_ctrl (.clk(clk), .mrreset(mrreset), .enable(enable), .reinit(reinit),
		.rx_valid(rx_valid), .rx_error(rx_error), .tx_done(tx_done), .rx_data(rx_data),
		.ps2_clk_o(ps2_clk_o), .rx_hold(rx_hold), .tx_start(tx_start), .ready(ready),
		.pkt_strobe(pkt_strobe), .frame_err(frame_err), .pkt_byte(pkt_byte),
		.pkt_index(pkt_index));

	mouse_position u_pos (.clk(clk), .mrreset(mrreset), .clear(clear),
		.pkt_strobe(pkt_strobe), .frame_err(frame_err), .pkt_index(pkt_index),
		.pkt_byte(pkt_byte), .buttons(buttons), .x_pos(x_pos), .y_pos(y_pos),
		.pkt_count(pkt_count), .err_count(err_count));

endmodule

`default_nettype wire

// File: source/mouse_apb_regs.sv
/* APB slave register block
   control with self-clearing pulses, status, position and count readback */
`timescale 1ns/100ps
`default_nettype none

module mouse_apb_regs
(
	input  wire                                clk,
	input  wire                                mrreset,
	input  wire                                psel,
	input  wire                                penable,
	input  wire                                pwrite,
	input  wire                                ready,      // handshake done
	input  wire  [4:0]                         paddr,
	input  wire  [31:0]                        pwdata,
	input  wire  [2:0]                         buttons,
	input  wire  [ps2_mouse_pkg::POS_BITS-1:0] x_pos,
	input  wire  [ps2_mouse_pkg::POS_BITS-1:0] y_pos,
	input  wire  [15:0]                        pkt_count,
	input  wire  [7:0]                         err_count,
	output logic [31:0]                        prdata,
	output logic                               enable,
	output logic                               clear,      // one cycle pulse
	output logic                               reinit      // one cycle pulse
);

	logic wr_ctrl;
	logic rd_en;
	logic [31:0] rd_data;

	assign wr_ctrl = psel & penable & pwrite & (paddr == ps2_mouse_pkg::REG_CTRL);
	assign rd_en = psel & ~pwrite;

	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (mrreset)
		begin
			enable <= 1'b0;
			clear <= 1'b0;
			reinit <= 1'b0;
		end
		else
		begin
			clear <= 1'b0;                 // pulses drop after one cycle
			reinit <= 1'b0;
			if (wr_ctrl)
			begin
				enable <= pwdata[0];
				clear <= pwdata[1];
				reinit <= pwdata[2];
			end
		end
	end

	// read mux, positions sign extended to the bus width
	always_comb
	begin
		case (paddr)
			ps2_mouse_pkg::REG_CTRL:
				rd_data = {31'd0, enable};                 // pulse bits read zero
			ps2_mouse_pkg::REG_STATUS:
				rd_data = {28'd0, ready, buttons};
			ps2_mouse_pkg::REG_XPOS:
				rd_data = {{(32-ps2_mouse_pkg::POS_BITS){x_pos[ps2_mouse_pkg::POS_BITS-1]}},
					x_pos};
			ps2_mouse_pkg::REG_YPOS:
				rd_data = {{(32-ps2_mouse_pkg::POS_BITS){y_pos[ps2_mouse_pkg::POS_BITS-1]}},
					y_pos};
			ps2_mouse_pkg::REG_COUNT:
				rd_data = {8'd0, err_count, pkt_count};
			default:
				rd_data = 32'd0;                           // unmapped
		endcase
	end

	assign prdata = rd_en ? rd_data : 32'd0;

endmodule

`default_nettype wire

// File: source/mouse_position.sv
/* packet decode, button latch, X and Y position accumulators, packet and error counters */
`timescale 1ns/100ps
`default_nettype none

module mouse_position
(
	input  wire                                clk,
	input  wire                                mrreset,
	input  wire                                clear,       // zero positions
	input  wire                                pkt_strobe,
	input  wire                                frame_err,
	input  wire  [1:0]                         pkt_index,
	input  wire  ps2_mouse_pkg::packet_byte_t  pkt_byte,
	output logic [2:0]                         buttons,     // middle, right, left
	output logic [ps2_mouse_pkg::POS_BITS-1:0] x_pos,
	output logic [ps2_mouse_pkg::POS_BITS-1:0] y_pos,
	output logic [15:0]                        pkt_count,
	output logic [7:0]                         err_count    // saturates
);

	ps2_mouse_pkg::packet_byte_t status_q;   // byte 1 of current packet
	logic [7:0] x_q;                         // byte 2
	logic [ps2_mouse_pkg::POS_BITS-1:0] dx;
	logic [ps2_mouse_pkg::POS_BITS-1:0] dy;
	logic last_byte;
	logic delta_ok;

	always_ff @(posedge clk)
	begin
		if (pkt_strobe && pkt_index == 2'd1)
			status_q <= pkt_byte;
		if (pkt_strobe && pkt_index == 2'd2)
			x_q <= pkt_byte.raw;
	end

	// 9-bit deltas, sign taken from the status byte
	assign dx = {{(ps2_mouse_pkg::POS_BITS-8){status_q.status.x_sign}}, x_q};
	assign dy = {{(ps2_mouse_pkg::POS_BITS-8){status_q.status.y_sign}}, pkt_byte.raw};
	assign last_byte = pkt_strobe && (pkt_index == 2'd3);
	assign delta_ok = ~(status_q.status.x_ovf | status_q.status.y_ovf);   // drop on overflow

	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (mrreset)
		begin
			buttons <= '0;
			x_pos <= '0;
			y_pos <= '0;
			pkt_count <= '0;
			err_count <= '0;
		end
		else
		begin
			if (clear)
			begin
				x_pos <= '0;                       // counts kept
				y_pos <= '0;
			end
			else if (last_byte && delta_ok)
			begin
				x_pos <= x_pos + dx;
				y_pos <= y_pos - dy;               // screen y grows downward
			end
			if (last_byte)
			begin
				buttons <= {status_q.status.middle, status_q.status.right, status_q.status.left};
				pkt_count <= pkt_count + 1'b1;
			end
			if (frame_err && err_count != 8'hFF)
				err_count <= err_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: source/ps2_mouse_ctrl.sv
/* PS/2 mouse controller FSM
   clock inhibit, enable command, acknowledge wait, packet byte sequencing, watchdog */
`timescale 1ns/100ps
`default_nettype none

module ps2_mouse_ctrl
(
	input  wire                         clk,
	input  wire                         mrreset,
	input  wire                         enable,      // software enable
	input  wire                         reinit,      // restart handshake pulse
	input  wire                         rx_valid,
	input  wire                         rx_error,
	input  wire                         tx_done,
	input  wire  [7:0]                  rx_data,
	output logic                        ps2_clk_o,   // 0 inhibits the device
	output logic                        rx_hold,
	output logic                        tx_start,
	output logic                        ready,       // handshake finished
	output logic                        pkt_strobe,
	output logic                        frame_err,
	output ps2_mouse_pkg::packet_byte_t pkt_byte,
	output logic [1:0]                  pkt_index    // 1 to 3 within packet
);

	logic [2:0] state_q;
	logic [2:0] state_d;
	logic [ps2_mouse_pkg::TIMER_BITS-1:0] timer_q;   // inhibit timer and watchdog
	logic timer_clr;
	logic timeout;
	logic hold_done;
	logic byte_ok;

	assign pkt_byte = rx_data;                       // same byte, union view
	assign timeout = (timer_q == ps2_mouse_pkg::TIMEOUT_CYCLES);
	assign hold_done = (timer_q == ps2_mouse_pkg::HOLD_CYCLES - 1'b1);
	assign byte_ok = rx_valid & ~rx_error;

	// --------------------------------------------------
	always_comb
	begin
		state_d = state_q;
		tx_start = 1'b0;
		pkt_strobe = 1'b0;
		frame_err = 1'b0;
		case (state_q)
			ps2_mouse_pkg::ST_IDLE:
				if (enable)
					state_d = ps2_mouse_pkg::ST_INHIBIT;
			ps2_mouse_pkg::ST_INHIBIT:
				if (hold_done)
				begin
					tx_start = 1'b1;                  // load command at end of hold
					state_d = ps2_mouse_pkg::ST_SEND;
				end
			ps2_mouse_pkg::ST_SEND:
				if (tx_done)
					state_d = ps2_mouse_pkg::ST_WAIT_ACK;
				else if (timeout)
					state_d = ps2_mouse_pkg::ST_INHIBIT;   // device never clocked
			ps2_mouse_pkg::ST_WAIT_ACK:
				if (byte_ok && rx_data == ps2_mouse_pkg::ACK_BYTE)
					state_d = ps2_mouse_pkg::ST_BYTE1;
				else if (rx_valid || timeout)
					state_d = ps2_mouse_pkg::ST_INHIBIT;   // wrong byte, retry
			ps2_mouse_pkg::ST_BYTE1:
				if (byte_ok && pkt_byte.status.always_one)
				begin
					pkt_strobe = 1'b1;
					state_d = ps2_mouse_pkg::ST_BYTE2;
				end
				else if (rx_valid)
					frame_err = 1'b1;                 // stay to resync
			ps2_mouse_pkg::ST_BYTE2:
				if (byte_ok)
				begin
					pkt_strobe = 1'b1;
					state_d = ps2_mouse_pkg::ST_BYTE3;
				end
				else if (rx_valid)
				begin
					frame_err = 1'b1;
					state_d = ps2_mouse_pkg::ST_BYTE1;
				end
				else if (timeout)
					state_d = ps2_mouse_pkg::ST_INHIBIT;   // stalled packet
			ps2_mouse_pkg::ST_BYTE3:
				if (byte_ok)
				begin
					pkt_strobe = 1'b1;
					state_d = ps2_mouse_pkg::ST_BYTE1;
				end
				else if (rx_valid)
				begin
					frame_err = 1'b1;
					state_d = ps2_mouse_pkg::ST_BYTE1;
				end
				else if (timeout)
					state_d = ps2_mouse_pkg::ST_INHIBIT;
			default:
				state_d = ps2_mouse_pkg::ST_IDLE;
		endcase
		if (!enable)
		begin
			state_d = ps2_mouse_pkg::ST_IDLE;         // disable wins over all
			tx_start = 1'b0;
		end
		else if (reinit)
		begin
			state_d = ps2_mouse_pkg::ST_INHIBIT;      // software restart
			tx_start = 1'b0;
		end
	end

	// timer restarts on every state change, idle and byte 1 wait forever
	assign timer_clr = (state_d != state_q) || reinit ||
		(state_q == ps2_mouse_pkg::ST_IDLE) || (state_q == ps2_mouse_pkg::ST_BYTE1);

	always_ff @(posedge clk)
	begin
		if (mrreset)
		begin
			state_q <= ps2_mouse_pkg::ST_IDLE;
			timer_q <= '0;
		end
		else
		begin
			state_q <= state_d;
			if (timer_clr)
				timer_q <= '0;
			else
				timer_q <= timer_q + 1'b1;
		end
	end

	// --------------------------------------------------
	assign ps2_clk_o = ~(enable && state_q == ps2_mouse_pkg::ST_INHIBIT);
	assign rx_hold = (state_q == ps2_mouse_pkg::ST_IDLE) ||
		(state_q == ps2_mouse_pkg::ST_INHIBIT) || (state_q == ps2_mouse_pkg::ST_SEND);
	assign ready = (state_q == ps2_mouse_pkg::ST_BYTE1) ||
		(state_q == ps2_mouse_pkg::ST_BYTE2) || (state_q == ps2_mouse_pkg::ST_BYTE3);

	always_comb
	begin
		case (state_q)
			ps2_mouse_pkg::ST_BYTE1: pkt_index = 2'd1;
			ps2_mouse_pkg::ST_BYTE2: pkt_index = 2'd2;
			ps2_mouse_pkg::ST_BYTE3: pkt_index = 2'd3;
			default:                 pkt_index = 2'd0;   // not in a packet
		endcase
	end

endmodule

`default_nettype wire

// File: source/ps2_tx_shifter.sv
/* PS/2 host-to-device transmitter for the enable command byte */
`timescale 1ns/100ps
`default_nettype none

module ps2_tx_shifter
(
	input  wire  clk,
	input  wire  mrreset,
	input  wire  clk_fall,             // device clock fall strobe
	input  wire  tx_start,             // load command frame
	output logic ps2_data_o,           // 1 releases the line
	output logic tx_done               // frame fully clocked out
);

	localparam logic [11:0] IDLE_WORD = 12'h001;    // marker alone in bit 0

	logic [11:0] shift_q;              // marker, stop, parity, data, start
	logic busy;
	logic last_shift;

	assign busy = (shift_q != IDLE_WORD);
	assign last_shift = clk_fall & busy & (shift_q[11:1] == 11'h001);   // marker moves to bit 0

	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (mrreset)
		begin
			shift_q <= IDLE_WORD;
			tx_done <= 1'b0;
		end
		else
		begin
			tx_done <= last_shift;
			if (tx_start)
				shift_q <= {1'b1, 1'b1, ~^ps2_mouse_pkg::CMD_ENABLE,
					ps2_mouse_pkg::CMD_ENABLE, 1'b0};  // odd parity frame
			else if (clk_fall && busy)
				shift_q <= {1'b0, shift_q[11:1]};     // next bit after each fall
		end
	end

	// start bit shows once the clock is released, idle keeps the line high
	assign ps2_data_o = shift_q[0];

endmodule

`default_nettype wire

// File: source/ps2_rx_shifter.sv
/* PS/2 device-to-host receiver
   synchronizer, clock fall detect, 11-bit frame shifter with checks */
`timescale 1ns/100ps
`default_nettype none

module ps2_rx_shifter
(
	input  wire        clk,
	input  wire        mrreset,
	input  wire        ps2_clk_i,      // raw PS/2 clock pin
	input  wire        ps2_data_i,     // raw PS/2 data pin
	input  wire        rx_hold,        // keep shifter cleared
	output logic       clk_fall,       // one cycle per device clock fall
	output logic       rx_valid,       // frame complete
	output logic       rx_error,       // parity or framing fault
	output logic [7:0] rx_data
);

	logic clk_meta;                    // first sync stage
	logic clk_sync;
	logic clk_prev;                    // delayed copy for edge detect
	logic data_meta;
	logic data_sync;
	logic [10:0] shift_q;              // stop, parity, data, start

	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (mrreset)
		begin
			clk_meta <= 1'b1;          // idle lines are high
			clk_sync <= 1'b1;
			clk_prev <= 1'b1;
			data_meta <= 1'b1;
			data_sync <= 1'b1;
		end
		else
		begin
			clk_meta <= ps2_clk_i;
			clk_sync <= clk_meta;
			clk_prev <= clk_sync;
			data_meta <= ps2_data_i;
			data_sync <= data_meta;
		end
	end

	assign clk_fall = clk_prev & ~clk_sync;    // high then low

	// preloaded with ones, start bit zero marks the end of a frame
	always_ff @(posedge clk)
	begin
		if (mrreset || rx_hold || rx_valid)
			shift_q <= '1;                     // clear after each frame
		else if (clk_fall)
			shift_q <= {data_sync, shift_q[10:1]};   // lsb first
	end

	assign rx_valid = ~shift_q[0];             // start bit reached bit 0
	assign rx_data = shift_q[8:1];
	assign rx_error = shift_q[0] | ~shift_q[10] | ~(^shift_q[9:1]);  // start, stop, odd parity

endmodule

`default_nettype wire

// File: source/ps2_mouse_pkg.sv
/* shared constants for the PS/2 mouse subsystem
   timing limits, APB register map, command codes, FSM states, packet byte union */
`default_nettype none

package ps2_mouse_pkg;

	// --------------------------------------------------
	localparam int TIMER_BITS = 16;                                   // watchdog width
	localparam logic [TIMER_BITS-1:0] HOLD_CYCLES = 16'd2048;         // clock inhibit length
	localparam logic [TIMER_BITS-1:0] TIMEOUT_CYCLES = 16'hFFFF;      // watchdog limit
	localparam int POS_BITS = 16;                                     // position counter width

	localparam logic [7:0] CMD_ENABLE = 8'hF4;                        // enable data reporting
	localparam logic [7:0] ACK_BYTE = 8'hFA;                          // device acknowledge

	// --------------------------------------------------
	localparam logic [4:0] REG_CTRL = 5'd0;                           // enable, clear, reinit
	localparam logic [4:0] REG_STATUS = 5'd4;                         // buttons and ready
	localparam logic [4:0] REG_XPOS = 5'd8;
	localparam logic [4:0] REG_YPOS = 5'd12;
	localparam logic [4:0] REG_COUNT = 5'd16;                         // packets and errors

	// --------------------------------------------------
	localparam logic [2:0] ST_IDLE = 3'd0;                            // waiting for enable
	localparam logic [2:0] ST_INHIBIT = 3'd1;                         // clock held low
	localparam logic [2:0] ST_SEND = 3'd2;                            // command going out
	localparam logic [2:0] ST_WAIT_ACK = 3'd3;
	localparam logic [2:0] ST_BYTE1 = 3'd4;                           // packet status byte
	localparam logic [2:0] ST_BYTE2 = 3'd5;                           // x delta
	localparam logic [2:0] ST_BYTE3 = 3'd6;                           // y delta

	// one received byte, read as packet status or as a plain delta
	typedef union packed {
		struct packed {
			logic y_ovf;                                              // y overflow
			logic x_ovf;                                              // x overflow
			logic y_sign;
			logic x_sign;
			logic always_one;                                         // sync bit of byte 1
			logic middle;
			logic right;
			logic left;
		} status;
		logic [7:0] raw;                                              // x or y delta
	} packet_byte_t;

endpackage

`default_nettype wire
